// ==== Bender.yml ====
package:
  name: sm83_regs

sources:
  - src/sm83_pkg.sv
  - src/sm83_reg_file.sv
  - src/sm83_addr_regs.sv
  - src/sm83_dbg_apb.sv
  - src/sm83_regs_top.sv
  - target: test
    files:
      - test/sm83_regs_properties.sv
      - test/tb_sm83_regs.sv

// ==== sm83_regs_top.f ====
src/sm83_pkg.sv
src/sm83_reg_file.sv
src/sm83_addr_regs.sv
src/sm83_dbg_apb.sv
src/sm83_regs_top.sv
test/sm83_regs_properties.sv
test/tb_sm83_regs.sv

// ==== src/sm83_addr_regs.sv ====
`timescale 1ns/1ps

module sm83_addr_regs (
	input  logic                               clk,
	input  logic                               rst_n,
	input  logic                               op_fire,
	input  sm83_pkg::op_e                      op_code,
	input  logic [sm83_pkg::data_w-1:0]        op_data,
	input  logic [sm83_pkg::data_w-1:0]        ir,
	input  logic                               dbg_wr,
	input  logic [sm83_pkg::apb_addr_w-1:0]    dbg_sel,
	input  logic [sm83_pkg::apb_data_w-1:0]    dbg_wdata,
	output logic [sm83_pkg::addr_w-1:0]        wz,
	output logic [sm83_pkg::addr_w-1:0]        sp,
	output logic [sm83_pkg::addr_w-1:0]        pc,
	output logic [sm83_pkg::addr_w-1:0]        addr
);

	import sm83_pkg::*;

	logic [data_w-1:0] z_q;
	logic [data_w-1:0] w_q;
	logic [addr_w-1:0] sp_q;
	logic [addr_w-1:0] pc_q;
	logic              idu_sp;	// IDU works on SP this cycle
	logic              idu_dec;
	logic [addr_w-1:0] idu_in;
	logic [addr_w-1:0] idu_out;
	logic [addr_w-1:0] rst_vec;
	logic              dbg_wz;
	logic              dbg_sp;
	logic              dbg_pc;

	assign idu_sp = op_fire && ((op_code == op_inc_sp) || (op_code == op_dec_sp));
	assign idu_dec = (op_code == op_dec_sp);

	// One shared incrementer/decrementer
	assign idu_in = idu_sp ? sp_q : pc_q;
	assign idu_out = idu_dec ? idu_in - 1'b1 : idu_in + 1'b1;

	// RST n: 0x00, 0x08 ... 0x38
	assign rst_vec = {{(addr_w-6){1'b0}}, ir[5:3], 3'b000};

	assign dbg_wz = dbg_wr && (dbg_sel == dbg_wz_addr);
	assign dbg_sp = dbg_wr && (dbg_sel == dbg_sp_addr);
	assign dbg_pc = dbg_wr && (dbg_sel == dbg_pc_addr);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			z_q <= '0;
			w_q <= '0;
		end else if (op_fire && (op_code == op_ld_z)) begin
			z_q <= op_data;
		end else if (op_fire && (op_code == op_ld_w)) begin
			w_q <= op_data;
		end else if (dbg_wz) begin
			{w_q, z_q} <= dbg_wdata[addr_w-1:0];
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sp_q <= sp_reset;
		end else if (op_fire && (op_code == op_ld_sp)) begin
			sp_q <= {w_q, z_q};
		end else if (idu_sp) begin
			sp_q <= idu_out;	// Result returns to its source
		end else if (dbg_sp) begin
			sp_q <= dbg_wdata[addr_w-1:0];
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc_q <= '0;
		end else if (op_fire && (op_code == op_jp)) begin
			pc_q <= {w_q, z_q};
		end else if (op_fire && (op_code == op_rst)) begin
			pc_q <= rst_vec;
		end else if (op_fire && (op_code == op_inc_pc)) begin
			pc_q <= idu_out;
		end else if (dbg_pc) begin
			pc_q <= dbg_wdata[addr_w-1:0];
		end
	end

	// Address bus follows the IDU source, so SP shows only during a stack step
	assign addr = idu_in;

	assign wz = {w_q, z_q};
	assign sp = sp_q;
	assign pc = pc_q;

endmodule

// ==== src/sm83_dbg_apb.sv ====
`timescale 1ns/1ps

module sm83_dbg_apb (
	input  logic                               clk,
	input  logic                               rst_n,
	input  logic [sm83_pkg::apb_addr_w-1:0]    paddr,
	input  logic                               psel,
	input  logic                               penable,
	input  logic                               pwrite,
	input  logic [sm83_pkg::apb_data_w-1:0]    pwdata,
	input  logic                               op_valid,
	input  logic [sm83_pkg::regs_w-1:0]        regs_flat,
	input  logic [sm83_pkg::addr_w-1:0]        wz,
	input  logic [sm83_pkg::addr_w-1:0]        sp,
	input  logic [sm83_pkg::addr_w-1:0]        pc,
	output logic [sm83_pkg::apb_data_w-1:0]    prdata,
	output logic                               pready,
	output logic                               pslverr,
	output logic                               op_ready,
	output logic                               op_fire,
	output logic                               dbg_wr,
	output logic [sm83_pkg::apb_addr_w-1:0]    dbg_sel,
	output logic [sm83_pkg::apb_data_w-1:0]    dbg_wdata
);

	import sm83_pkg::*;

	logic              halt;
	logic              access;	// APB access phase
	logic              hit_ctrl;
	logic              hit_reg;
	logic              hit_word;	// W:Z, SP or PC
	logic              wr_reg;	// Write aimed at a register
	logic [data_w-1:0] reg_byte;

	assign access = psel && penable;

	assign hit_ctrl = (paddr == dbg_ctrl_addr);
	assign hit_reg = (paddr[7:5] == dbg_reg_base[7:5]) && (paddr[1:0] == 2'b00);
	assign hit_word = (paddr == dbg_wz_addr) || (paddr == dbg_sp_addr) || (paddr == dbg_pc_addr);
	assign wr_reg = access && pwrite && (hit_reg || hit_word);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			halt <= 1'b0;
		end else if (access && pwrite && hit_ctrl) begin
			halt <= pwdata[0];	// Control write never blocked
		end
	end

	// Halt is the only back-pressure
	assign op_ready = !halt;
	assign op_fire = op_valid && op_ready;

	assign dbg_wr = wr_reg && halt;
	assign dbg_sel = paddr;
	assign dbg_wdata = pwdata;

	assign reg_byte = regs_flat[paddr[4:2]*data_w +: data_w];

	always_comb begin
		prdata = '0;
		if (hit_ctrl) prdata = {{(apb_data_w-1){1'b0}}, halt};
		else if (hit_reg) prdata = {{(apb_data_w-data_w){1'b0}}, reg_byte};
		else if (paddr == dbg_wz_addr) prdata = wz;
		else if (paddr == dbg_sp_addr) prdata = sp;
		else if (paddr == dbg_pc_addr) prdata = pc;
	end

	assign pready = 1'b1;	// No wait states
	assign pslverr = access && (!(hit_ctrl || hit_reg || hit_word) || (wr_reg && !halt));

endmodule

// ==== src/sm83_pkg.sv ====
package sm83_pkg;

	localparam int data_w = 8;
	localparam int addr_w = 16;
	localparam int apb_addr_w = 8;
	localparam int apb_data_w = addr_w;	// Widest readable register
	localparam int n_regs = 8;
	localparam int regs_w = n_regs * data_w;

	localparam logic [addr_w-1:0] sp_reset = 16'hfffe;

	// Micro-operations issued in place of the decoder
	typedef enum logic [3:0] {
		op_nop    = 4'd0,
		op_ld_r   = 4'd1,	// reg <= op_data
		op_rd_r   = 4'd2,	// rd_data <= reg
		op_ld_z   = 4'd3,
		op_ld_w   = 4'd4,
		op_ld_sp  = 4'd5,	// SP <= W:Z
		op_jp     = 4'd6,	// PC <= W:Z
		op_inc_pc = 4'd7,
		op_inc_sp = 4'd8,
		op_dec_sp = 4'd9,
		op_rst    = 4'd10	// PC <= IR[5:3] * 8
	} op_e;

	// Byte register select, also the debug window index
	typedef enum logic [2:0] {
		r_b  = 3'd0,
		r_c  = 3'd1,
		r_d  = 3'd2,
		r_e  = 3'd3,
		r_h  = 3'd4,
		r_l  = 3'd5,
		r_a  = 3'd6,
		r_ir = 3'd7
	} reg_e;

	// Debug address map, byte addresses
	localparam logic [apb_addr_w-1:0] dbg_ctrl_addr = 8'h00;	// Bit 0 halt
	localparam logic [apb_addr_w-1:0] dbg_reg_base = 8'h40;	// Plus 4 * reg_e
	localparam logic [apb_addr_w-1:0] dbg_wz_addr = 8'h60;
	localparam logic [apb_addr_w-1:0] dbg_sp_addr = 8'h64;
	localparam logic [apb_addr_w-1:0] dbg_pc_addr = 8'h68;

endpackage

// ==== src/sm83_reg_file.sv ====
`timescale 1ns/1ps

module sm83_reg_file (
	input  logic                               clk,
	input  logic                               rst_n,
	input  logic                               op_fire,
	input  sm83_pkg::op_e                      op_code,
	input  sm83_pkg::reg_e                     op_reg,
	input  logic [sm83_pkg::data_w-1:0]        op_data,
	input  logic                               dbg_wr,
	input  logic [sm83_pkg::apb_addr_w-1:0]    dbg_sel,
	input  logic [sm83_pkg::apb_data_w-1:0]    dbg_wdata,
	output logic                               rd_valid,
	output logic [sm83_pkg::data_w-1:0]        rd_data,
	output logic [sm83_pkg::regs_w-1:0]        regs_flat,
	output logic [sm83_pkg::data_w-1:0]        ir
);

	import sm83_pkg::*;

	logic [data_w-1:0] regs [n_regs];	// B C D E H L A IR
	logic              op_ld;
	logic              op_rd;
	logic              dbg_hit;
	logic [2:0]        dbg_idx;

	assign op_ld = op_fire && (op_code == op_ld_r);
	assign op_rd = op_fire && (op_code == op_rd_r);

	// Window 0x40..0x5c, one register per word
	assign dbg_hit = dbg_wr && (dbg_sel[7:5] == dbg_reg_base[7:5]) && (dbg_sel[1:0] == 2'b00);
	assign dbg_idx = dbg_sel[4:2];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < n_regs; i++) begin
				regs[i] <= '0;
			end
		end else if (op_ld) begin
			regs[op_reg] <= op_data;
		end else if (dbg_hit) begin
			regs[dbg_idx] <= dbg_wdata[data_w-1:0];	// Only reachable while halted
		end
	end

	// Read result, valid for one cycle
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_valid <= 1'b0;
		end else begin
			rd_valid <= op_rd;
		end
	end

	always_ff @(posedge clk) begin
		if (op_rd) begin
			rd_data <= regs[op_reg];
		end
	end

	// Flattened copy for debug readback
	always_comb begin
		for (int i = 0; i < n_regs; i++) begin
			regs_flat[i*data_w +: data_w] = regs[i];
		end
	end

	assign ir = regs[r_ir];	// Feeds the restart vector

endmodule

// ==== src/sm83_regs_top.sv ====
`timescale 1ns/1ps

module sm83_regs_top (
	input  logic                               clk,
	input  logic                               rst_n,
	input  logic                               op_valid,
	output logic                               op_ready,
	input  sm83_pkg::op_e                      op_code,
	input  sm83_pkg::reg_e                     op_reg,
	input  logic [sm83_pkg::data_w-1:0]        op_data,
	output logic                               rd_valid,
	output logic [sm83_pkg::data_w-1:0]        rd_data,
	output logic [sm83_pkg::addr_w-1:0]        addr,
	input  logic [sm83_pkg::apb_addr_w-1:0]    paddr,
	input  logic                               psel,
	input  logic                               penable,
	input  logic                               pwrite,
	input  logic [sm83_pkg::apb_data_w-1:0]    pwdata,
	output logic [sm83_pkg::apb_data_w-1:0]    prdata,
	output logic                               pready,
	output logic                               pslverr
);

	import sm83_pkg::*;

	logic                  op_fire;
	logic                  dbg_wr;
	logic [apb_addr_w-1:0] dbg_sel;
	logic [apb_data_w-1:0] dbg_wdata;
	logic [regs_w-1:0]     regs_flat;
	logic [data_w-1:0]     ir;
	logic [addr_w-1:0]     wz;
	logic [addr_w-1:0]     sp;
	logic [addr_w-1:0]     pc;

	sm83_dbg_apb u_dbg (
		.clk(clk), .rst_n(rst_n), .paddr(paddr), .psel(psel), .penable(penable),
		.pwrite(pwrite), .pwdata(pwdata), .op_valid(op_valid), .regs_flat(regs_flat),
		.wz(wz), .sp(sp), .pc(pc), .prdata(prdata), .pready(pready), .pslverr(pslverr),
		.op_ready(op_ready), .op_fire(op_fire), .dbg_wr(dbg_wr), .dbg_sel(dbg_sel),
		.dbg_wdata(dbg_wdata)
	);

	sm83_reg_file u_reg_file (
		.clk(clk), .rst_n(rst_n), .op_fire(op_fire), .op_code(op_code), .op_reg(op_reg),
		.op_data(op_data), .dbg_wr(dbg_wr), .dbg_sel(dbg_sel), .dbg_wdata(dbg_wdata),
		.rd_valid(rd_valid), .rd_data(rd_data), .regs_flat(regs_flat), .ir(ir)
	);

	sm83_addr_regs u_addr_regs (
		.clk(clk), .rst_n(rst_n), .op_fire(op_fire), .op_code(op_code), .op_data(op_data),
		.ir(ir), .dbg_wr(dbg_wr), .dbg_sel(dbg_sel), .dbg_wdata(dbg_wdata),
		.wz(wz), .sp(sp), .pc(pc), .addr(addr)
	);

endmodule

// ==== test/sm83_regs_properties.sv ====
`timescale 1ns/1ps

module sm83_regs_properties (
	input logic                            clk,
	input logic                            rst_n,
	input logic                            op_valid,
	input logic                            op_ready,
	input sm83_pkg::op_e                   op_code,
	input logic                            rd_valid,
	input logic [sm83_pkg::addr_w-1:0]     addr,
	input logic [sm83_pkg::addr_w-1:0]     wz,
	input logic [sm83_pkg::addr_w-1:0]     sp,
	input logic [sm83_pkg::addr_w-1:0]     pc,
	input logic [sm83_pkg::data_w-1:0]     ir,
	input logic [sm83_pkg::apb_addr_w-1:0] paddr,
	input logic                            psel,
	input logic                            penable,
	input logic                            pwrite,
	input logic                            pready,
	input logic                            pslverr
);

	import sm83_pkg::*;

	int   fail_count = 0;	// Polled by the testbench
	logic fire;
	logic apb_wr;
	logic reg_addr;

	assign fire = op_valid && op_ready;
	assign apb_wr = psel && penable && pwrite;
	assign reg_addr = (paddr[7:5] == 3'b010 && paddr[1:0] == 2'b00) || paddr == dbg_wz_addr ||
		paddr == dbg_sp_addr || paddr == dbg_pc_addr;

	// Read result one cycle after acceptance, and only then
	a_rd_after: assert property (@(posedge clk) disable iff (!rst_n)
		fire && op_code == op_rd_r |=> rd_valid)
		else begin fail_count++; $error("Error at %0t: rd_valid missing", $time); end
	a_rd_only: assert property (@(posedge clk) disable iff (!rst_n)
		rd_valid |-> $past(fire && op_code == op_rd_r))
		else begin fail_count++; $error("Error at %0t: stray rd_valid", $time); end

	a_inc_pc: assert property (@(posedge clk) disable iff (!rst_n)
		fire && op_code == op_inc_pc |=> pc == $past(pc) + 16'd1)
		else begin fail_count++; $error("Error at %0t: PC not incremented", $time); end

	// Stack step shows old SP on addr
	a_inc_sp: assert property (@(posedge clk) disable iff (!rst_n)
		fire && op_code == op_inc_sp |-> addr == sp ##1 sp == $past(sp) + 16'd1)
		else begin fail_count++; $error("Error at %0t: SP increment wrong", $time); end
	a_dec_sp: assert property (@(posedge clk) disable iff (!rst_n)
		fire && op_code == op_dec_sp |-> addr == sp ##1 sp == $past(sp) - 16'd1)
		else begin fail_count++; $error("Error at %0t: SP decrement wrong", $time); end

	a_jp: assert property (@(posedge clk) disable iff (!rst_n)
		fire && op_code == op_jp |=> pc == $past(wz))
		else begin fail_count++; $error("Error at %0t: jump target wrong", $time); end
	a_rst: assert property (@(posedge clk) disable iff (!rst_n)
		fire && op_code == op_rst |=> pc == $past(ir[5:3]) * 16'd8)
		else begin fail_count++; $error("Error at %0t: restart vector wrong", $time); end

	// Frozen while halted unless debug writes
	a_halt_hold: assert property (@(posedge clk) disable iff (!rst_n)
		!op_ready && !apb_wr |=> $stable(pc) && $stable(sp) && $stable(wz) && !rd_valid)
		else begin fail_count++; $error("Error at %0t: state changed while halted", $time); end

	a_run_wr_err: assert property (@(posedge clk) disable iff (!rst_n)
		apb_wr && op_ready && reg_addr |-> pslverr)
		else begin fail_count++; $error("Error at %0t: no pslverr on running write", $time); end

	a_pready: assert property (@(posedge clk) disable iff (!rst_n) pready)
		else begin fail_count++; $error("Error at %0t: pready low", $time); end

endmodule

bind sm83_regs_top sm83_regs_properties props0 (
	.clk(clk), .rst_n(rst_n), .op_valid(op_valid), .op_ready(op_ready), .op_code(op_code),
	.rd_valid(rd_valid), .addr(addr), .wz(wz), .sp(sp), .pc(pc), .ir(ir), .paddr(paddr),
	.psel(psel), .penable(penable), .pwrite(pwrite), .pready(pready), .pslverr(pslverr)
);

// ==== test/tb_sm83_regs.sv ====
`timescale 1ns/1ps

module tb_sm83_regs;

	import sm83_pkg::*;

	localparam int max_cycles = 400;	// Tests run about 70 cycles

	logic                  clk = 1'b0;
	logic                  rst_n;
	logic                  op_valid;
	logic                  op_ready;
	op_e                   op_code;
	reg_e                  op_reg;
	logic [data_w-1:0]     op_data;
	logic                  rd_valid;
	logic [data_w-1:0]     rd_data;
	logic [addr_w-1:0]     addr;
	logic [apb_addr_w-1:0] paddr;
	logic                  psel;
	logic                  penable;
	logic                  pwrite;
	logic [apb_data_w-1:0] pwdata;
	logic [apb_data_w-1:0] prdata;
	logic                  pready;
	logic                  pslverr;

	int                    cycles = 0;
	int                    seed = 32'h45b9;
	logic [data_w-1:0]     shadow [n_regs];	// Last value loaded per register
	logic [addr_w-1:0]     exp_pc;
	logic [apb_data_w-1:0] rdata;
	logic                  err;

	sm83_regs_top dut0 (.*);

	always #50 clk = ~clk;

	task automatic stop_failed(input string msg);
		$display("Error at %0t: %s", $time, msg);
		$display("Test failed");
		$fatal(1);
	endtask

	// Timeout and assertion monitor
	always @(posedge clk) begin
		cycles++;
		if (cycles >= max_cycles) begin
			stop_failed("timeout, run did not finish");
		end else if (dut0.props0.fail_count != 0) begin
			stop_failed("concurrent assertion failed");
		end
	end

	task automatic check_val(input string what, input logic [15:0] got, input logic [15:0] exp);
		assert (got === exp)
		else stop_failed($sformatf("%s got %h expected %h", what, got, exp));
	endtask

	task automatic issue_op(input op_e code, input reg_e r, input logic [data_w-1:0] d);
		op_valid = 1'b1;
		op_code = code;
		op_reg = r;
		op_data = d;
		while (!op_ready) begin
			@(posedge clk);
			#1;
		end
		@(posedge clk);	// Accepted here
		#1;
		op_valid = 1'b0;
		op_code = op_nop;
	endtask

	task automatic read_reg_check(input reg_e r);
		issue_op(op_rd_r, r, 8'h00);
		while (!rd_valid) begin
			@(posedge clk);
			#1;
		end
		check_val("rd_data", rd_data, shadow[r]);
	endtask

	task automatic apb_xfer(input logic wr, input logic [apb_addr_w-1:0] a,
		input logic [apb_data_w-1:0] d, output logic [apb_data_w-1:0] rd, output logic e);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = wr;
		paddr = a;
		pwdata = d;
		@(posedge clk);
		#1;
		penable = 1'b1;
		@(negedge clk);
		rd = prdata;	// Combinational in access phase
		e = pslverr;
		@(posedge clk);
		#1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	initial begin
		rst_n = 1'b0;
		op_valid = 1'b0;
		op_code = op_nop;
		op_reg = r_b;
		op_data = '0;
		paddr = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pwdata = '0;
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;

		check_val("op_ready after reset", op_ready, 1'b1);
		check_val("rd_valid after reset", rd_valid, 1'b0);
		check_val("addr after reset", addr, 16'h0000);
		apb_xfer(1'b0, dbg_sp_addr, '0, rdata, err);
		check_val("SP after reset", rdata, sp_reset);

		for (int i = 0; i < n_regs; i++) begin
			shadow[i] = $random(seed);
			issue_op(op_ld_r, reg_e'(i), shadow[i]);
		end
		for (int i = 0; i < n_regs; i++) begin
			read_reg_check(reg_e'(i));
		end

		issue_op(op_ld_z, r_b, 8'h34);
		issue_op(op_ld_w, r_b, 8'h12);
		issue_op(op_jp, r_b, 8'h00);
		exp_pc = 16'h1234;
		check_val("addr after jp", addr, exp_pc);
		repeat (3) begin
			issue_op(op_inc_pc, r_b, 8'h00);
			exp_pc++;
			check_val("addr after inc_pc", addr, exp_pc);
		end
		issue_op(op_ld_sp, r_b, 8'h00);	// SP <= 0x1234
		issue_op(op_inc_sp, r_b, 8'h00);
		issue_op(op_dec_sp, r_b, 8'h00);
		issue_op(op_dec_sp, r_b, 8'h00);
		apb_xfer(1'b0, dbg_sp_addr, '0, rdata, err);
		check_val("SP after steps", rdata, 16'h1233);
		issue_op(op_rst, r_b, 8'h00);
		exp_pc = shadow[r_ir][5:3] * 16'd8;
		check_val("addr after rst", addr, exp_pc);

		// Halt, then hold an op pending
		apb_xfer(1'b1, dbg_ctrl_addr, 16'h0001, rdata, err);
		op_valid = 1'b1;
		op_code = op_inc_pc;
		repeat (3) @(posedge clk);
		#1;
		check_val("op_ready while halted", op_ready, 1'b0);
		check_val("addr while halted", addr, exp_pc);
		apb_xfer(1'b1, dbg_reg_base + 8'h04, 16'h005a, rdata, err);
		check_val("pslverr halted write", err, 1'b0);
		shadow[r_c] = 8'h5a;
		apb_xfer(1'b0, dbg_reg_base + 8'h04, '0, rdata, err);
		check_val("C readback", rdata, 16'h005a);
		apb_xfer(1'b1, dbg_sp_addr, 16'hbeef, rdata, err);
		apb_xfer(1'b0, dbg_sp_addr, '0, rdata, err);
		check_val("SP readback", rdata, 16'hbeef);
		apb_xfer(1'b1, dbg_ctrl_addr, 16'h0000, rdata, err);
		@(posedge clk);	// Pending inc_pc accepted
		#1;
		op_valid = 1'b0;
		op_code = op_nop;
		exp_pc++;
		@(posedge clk);
		#1;
		check_val("addr after release", addr, exp_pc);

		// Running debug writes are rejected
		apb_xfer(1'b1, dbg_reg_base + 8'h08, 16'h00a5, rdata, err);
		check_val("pslverr running write", err, 1'b1);
		apb_xfer(1'b0, dbg_reg_base + 8'h08, '0, rdata, err);
		check_val("D kept", rdata, shadow[r_d]);
		apb_xfer(1'b1, dbg_sp_addr, 16'h0101, rdata, err);
		check_val("pslverr running SP write", err, 1'b1);
		apb_xfer(1'b0, dbg_sp_addr, '0, rdata, err);
		check_val("SP kept", rdata, 16'hbeef);

		for (int i = 0; i < n_regs; i++) begin
			read_reg_check(reg_e'(i));
		end

		@(posedge clk);
		#1;
		if (dut0.props0.fail_count == 0) begin
			$display("Test completed successfully");
			$finish;
		end else begin
			$display("Test failed");
			$fatal(1);
		end
	end

endmodule
